// ==== Makefile ====
SIM      = verilator
FLAGS    = --binary --timing --assert --timescale 1ns/1ns -Wno-fatal
TOP      = portalTopTb
FILELIST = portalTop.f

SOURCES  = $(wildcard source/*.sv) $(wildcard verif/*.sv) $(wildcard verif/*.svh)
BIN      = obj_dir/V$(TOP)

.PHONY: all run clean

all: $(BIN)

$(BIN): $(SOURCES) $(FILELIST)
	$(SIM) $(FLAGS) --top-module $(TOP) -f $(FILELIST)

run: $(BIN)
	@out="$$(./$(BIN))"; echo "$$out"; echo "$$out" | grep -q "PASS: all tests"

clean:
	rm -rf obj_dir

// ==== portalTop.f ====
+incdir+verif
source/portalPkg.sv
source/fifo1.sv
source/burstSplitter.sv
source/portalWritePath.sv
source/portalReadPath.sv
source/userEcho.sv
source/portalTop.sv
verif/portalTopTb.sv

// ==== source/burstSplitter.sv ====
`timescale 1ns/1ns
`default_nettype none

module burstSplitter (
  input  logic                         CLK,
  input  logic                         nRST,
  input  logic                         reqValid,
  output logic                         reqReady,
  input  logic [portalPkg::ADDR_W-1:0] reqAddr,
  input  logic [portalPkg::LEN_W-1:0]  reqLen,
  input  logic [portalPkg::ID_W-1:0]   reqId,
  output logic                         beatValid,
  input  logic                         beatReady,
  output logic [portalPkg::OFF_W-1:0]  beatOffset,
  output logic [portalPkg::ID_W-1:0]   beatId,
  output logic                         beatLast,
  output logic                         beatCtrl,
  output logic                         beatInd
);

  localparam int BEAT_W = portalPkg::OFF_W + portalPkg::ID_W + 3;

  typedef enum logic {IDLE, BUSY} state_t;

  state_t state;
  logic [portalPkg::OFF_W-1:0] offset;
  logic [portalPkg::LEN_W-1:0] remain;  // Beats left after the current one
  logic [portalPkg::ID_W-1:0] id;
  logic ctrl;
  logic ind;
  logic accept;
  logic beatEnq;
  logic beatFull;
  logic beatEmpty;
  logic [BEAT_W-1:0] beatIn;
  logic [BEAT_W-1:0] beatOut;

  assign reqReady = (state == IDLE);
  assign accept = reqValid && reqReady;
  assign beatEnq = (state == BUSY) && !beatFull;
  assign beatIn = {offset, id, remain == '0, ctrl, ind};

  always_ff @(posedge CLK) begin
    if (!nRST) begin
      state <= IDLE;
      remain <= '0;
    end else if (accept) begin
      state <= BUSY;
      remain <= reqLen;
    end else if (beatEnq) begin
      remain <= remain - portalPkg::LEN_W'(1);
      if (remain == '0) state <= IDLE;  // Last beat out
    end
  end

  always_ff @(posedge CLK) begin
    if (accept) begin
      offset <= reqAddr[portalPkg::OFF_W-1:0];
      id <= reqId;
      ctrl <= (reqAddr[portalPkg::PAGE_HI:portalPkg::PAGE_LO] == '0);
      ind <= reqAddr[portalPkg::PORTAL_SEL_BIT];
    end else if (beatEnq) begin
      offset <= offset + portalPkg::OFF_W'(4);  // One word per beat
    end
  end

  fifo1 #(.WIDTH(BEAT_W)) i_beatStage (
    .CLK(CLK), .nRST(nRST),
    .enq(beatEnq), .din(beatIn),
    .deq(beatValid && beatReady), .dout(beatOut),
    .full(beatFull), .empty(beatEmpty)
  );

  assign beatValid = !beatEmpty;
  assign {beatOffset, beatId, beatLast, beatCtrl, beatInd} = beatOut;

  // Count never climbs while busy
  assert property (@(posedge CLK) disable iff (!nRST)
    (state == BUSY) |=> (state == IDLE || remain <= $past(remain)))
    else $error("burstSplitter: beat count wrapped");

endmodule

`default_nettype wire

// ==== source/fifo1.sv ====
`timescale 1ns/1ns
`default_nettype none

module fifo1 #(
  parameter int WIDTH = 8
) (
  input  logic             CLK,
  input  logic             nRST,
  input  logic             enq,
  input  logic [WIDTH-1:0] din,
  input  logic             deq,
  output logic [WIDTH-1:0] dout,
  output logic             full,
  output logic             empty
);

  assign empty = !full;

  always_ff @(posedge CLK) begin
    if (!nRST) begin
      full <= 1'b0;
    end else if (enq) begin
      full <= 1'b1;
    end else if (deq) begin
      full <= 1'b0;
    end
  end

  always_ff @(posedge CLK) begin
    if (enq) begin
      dout <= din;
    end
  end

  // Producer and consumer sit in other modules
  assert property (@(posedge CLK) disable iff (!nRST) enq |-> !full)
    else $error("fifo1: enqueue while full");

  assert property (@(posedge CLK) disable iff (!nRST) deq |-> !empty)
    else $error("fifo1: dequeue while empty");

endmodule

`default_nettype wire

// ==== source/portalPkg.sv ====
`default_nettype none

package portalPkg;

  // Bus widths
  localparam int DATA_W = 32;
  localparam int ADDR_W = 13;
  localparam int ID_W = 6;
  localparam int LEN_W = 4;  // Beats = length + 1
  localparam int OFF_W = 5;

  // Address fields
  localparam int PORTAL_SEL_BIT = 12;  // 0 request, 1 indication
  localparam int PAGE_HI = 11;
  localparam int PAGE_LO = 5;

  // Control page map
  typedef enum logic [OFF_W-1:0] {
    INTR_STATUS      = 5'h00,
    INTR_ENABLE      = 5'h04,
    NUM_TILES        = 5'h08,
    IND_QUEUE_STATUS = 5'h0C,
    PORTAL_ID        = 5'h10,
    NUM_PORTALS      = 5'h14
  } ctrlReg_t;

  // Data page offset of the user write-ready bit
  localparam logic [OFF_W-1:0] WRITE_READY_OFF = 5'h04;

  localparam logic [DATA_W-1:0] REQ_PORTAL_ID = 32'd5;
  localparam logic [DATA_W-1:0] IND_PORTAL_ID = 32'd6;
  localparam logic [DATA_W-1:0] TILE_COUNT = 32'd1;
  localparam logic [DATA_W-1:0] PORTAL_COUNT = 32'd2;

  localparam logic [DATA_W-1:0] FILLER_WORD = 32'h005A05A0;  // Unmapped control offset

endpackage

`default_nettype wire

// ==== source/portalReadPath.sv ====
`timescale 1ns/1ns
`default_nettype none

module portalReadPath (
  input  logic                         CLK,
  input  logic                         nRST,
  input  logic                         beatValid,
  output logic                         beatReady,
  input  logic [portalPkg::OFF_W-1:0]  beatOffset,
  input  logic [portalPkg::ID_W-1:0]   beatId,
  input  logic                         beatLast,
  input  logic                         beatCtrl,
  input  logic                         beatInd,
  output logic                         rValid,
  input  logic                         rReady,
  output logic [portalPkg::DATA_W-1:0] rData,
  output logic [portalPkg::ID_W-1:0]   rId,
  output logic                         rLast,
  input  logic                         indValid,
  input  logic [portalPkg::DATA_W-1:0] indData,
  output logic                         indDeq,
  input  logic                         intrEnable,
  input  logic                         reqReady,
  output logic                         interrupt
);

  localparam int R_W = portalPkg::DATA_W + portalPkg::ID_W + 1;

  logic consume;
  logic rFull;
  logic rEmpty;
  logic [portalPkg::DATA_W-1:0] ctrlWord;
  logic [portalPkg::DATA_W-1:0] dataWord;
  logic [portalPkg::DATA_W-1:0] word;

  assign consume = beatValid && !rFull;
  assign beatReady = consume;
  assign indDeq = consume && beatInd && !beatCtrl && indValid;
  assign rValid = !rEmpty;

  always_comb begin
    case (portalPkg::ctrlReg_t'(beatOffset))
      portalPkg::INTR_STATUS: ctrlWord = {{(portalPkg::DATA_W-1){1'b0}}, indValid};
      portalPkg::INTR_ENABLE: ctrlWord = {{(portalPkg::DATA_W-1){1'b0}}, intrEnable};
      portalPkg::NUM_TILES: ctrlWord = portalPkg::TILE_COUNT;
      portalPkg::IND_QUEUE_STATUS: ctrlWord = {{(portalPkg::DATA_W-1){1'b0}}, indValid};
      portalPkg::PORTAL_ID: begin
        ctrlWord = beatInd ? portalPkg::IND_PORTAL_ID : portalPkg::REQ_PORTAL_ID;
      end
      portalPkg::NUM_PORTALS: ctrlWord = portalPkg::PORTAL_COUNT;
      default: ctrlWord = portalPkg::FILLER_WORD;
    endcase
  end

  always_comb begin
    if (beatInd) begin
      dataWord = indValid ? indData : '0;  // Empty queue reads zero
    end else if (beatOffset == portalPkg::WRITE_READY_OFF) begin
      dataWord = {{(portalPkg::DATA_W-1){1'b0}}, reqReady};
    end else begin
      dataWord = '0;
    end
  end

  assign word = beatCtrl ? ctrlWord : dataWord;

  fifo1 #(.WIDTH(R_W)) i_readStage (
    .CLK(CLK), .nRST(nRST),
    .enq(consume), .din({word, beatId, beatLast}),
    .deq(rValid && rReady), .dout({rData, rId, rLast}),
    .full(rFull), .empty(rEmpty)
  );

  always_ff @(posedge CLK) begin
    if (!nRST) begin
      interrupt <= 1'b0;
    end else begin
      interrupt <= indValid && intrEnable;
    end
  end

endmodule

`default_nettype wire

// ==== source/portalTop.sv ====
`timescale 1ns/1ns
`default_nettype none

module portalTop #(
  parameter int ECHO_DEPTH = 4
) (
  input  logic                         CLK,
  input  logic                         nRST,
  input  logic                         awValid,
  output logic                         awReady,
  input  logic [portalPkg::ADDR_W-1:0] awAddr,
  input  logic [portalPkg::ID_W-1:0]   awId,
  input  logic [portalPkg::LEN_W-1:0]  awLen,
  input  logic                         wValid,
  output logic                         wReady,
  input  logic [portalPkg::DATA_W-1:0] wData,
  input  logic                         wLast,
  output logic                         bValid,
  input  logic                         bReady,
  output logic [portalPkg::ID_W-1:0]   bId,
  input  logic                         arValid,
  output logic                         arReady,
  input  logic [portalPkg::ADDR_W-1:0] arAddr,
  input  logic [portalPkg::ID_W-1:0]   arId,
  input  logic [portalPkg::LEN_W-1:0]  arLen,
  output logic                         rValid,
  input  logic                         rReady,
  output logic [portalPkg::DATA_W-1:0] rData,
  output logic [portalPkg::ID_W-1:0]   rId,
  output logic                         rLast,
  output logic                         interrupt
);

  logic wrBeatValid, wrBeatReady, wrBeatLast, wrBeatCtrl, wrBeatInd;
  logic rdBeatValid, rdBeatReady, rdBeatLast, rdBeatCtrl, rdBeatInd;
  logic [portalPkg::OFF_W-1:0] wrBeatOffset, rdBeatOffset;
  logic [portalPkg::ID_W-1:0] wrBeatId, rdBeatId;
  logic reqEnq, reqReady, indDeq, indValid, intrEnable;
  logic [portalPkg::DATA_W-1:0] reqData, indData;

  burstSplitter i_wrSplit (
    .CLK(CLK), .nRST(nRST),
    .reqValid(awValid), .reqReady(awReady), .reqAddr(awAddr), .reqLen(awLen), .reqId(awId),
    .beatValid(wrBeatValid), .beatReady(wrBeatReady), .beatOffset(wrBeatOffset),
    .beatId(wrBeatId), .beatLast(wrBeatLast), .beatCtrl(wrBeatCtrl), .beatInd(wrBeatInd)
  );

  burstSplitter i_rdSplit (
    .CLK(CLK), .nRST(nRST),
    .reqValid(arValid), .reqReady(arReady), .reqAddr(arAddr), .reqLen(arLen), .reqId(arId),
    .beatValid(rdBeatValid), .beatReady(rdBeatReady), .beatOffset(rdBeatOffset),
    .beatId(rdBeatId), .beatLast(rdBeatLast), .beatCtrl(rdBeatCtrl), .beatInd(rdBeatInd)
  );

  portalWritePath i_writePath (
    .CLK(CLK), .nRST(nRST),
    .beatValid(wrBeatValid), .beatReady(wrBeatReady), .beatOffset(wrBeatOffset),
    .beatId(wrBeatId), .beatLast(wrBeatLast), .beatCtrl(wrBeatCtrl), .beatInd(wrBeatInd),
    .awAccept(awValid && awReady),
    .wValid(wValid), .wReady(wReady), .wData(wData), .wLast(wLast),
    .bValid(bValid), .bReady(bReady), .bId(bId),
    .reqEnq(reqEnq), .reqData(reqData), .reqReady(reqReady), .intrEnable(intrEnable)
  );

  portalReadPath i_readPath (
    .CLK(CLK), .nRST(nRST),
    .beatValid(rdBeatValid), .beatReady(rdBeatReady), .beatOffset(rdBeatOffset),
    .beatId(rdBeatId), .beatLast(rdBeatLast), .beatCtrl(rdBeatCtrl), .beatInd(rdBeatInd),
    .rValid(rValid), .rReady(rReady), .rData(rData), .rId(rId), .rLast(rLast),
    .indValid(indValid), .indData(indData), .indDeq(indDeq),
    .intrEnable(intrEnable), .reqReady(reqReady), .interrupt(interrupt)
  );

  userEcho #(.DEPTH(ECHO_DEPTH)) i_userEcho (
    .CLK(CLK), .nRST(nRST),
    .reqEnq(reqEnq), .reqData(reqData), .reqReady(reqReady),
    .indDeq(indDeq), .indValid(indValid), .indData(indData)
  );

endmodule

`default_nettype wire

// ==== source/portalWritePath.sv ====
`timescale 1ns/1ns
`default_nettype none

module portalWritePath (
  input  logic                         CLK,
  input  logic                         nRST,
  input  logic                         beatValid,
  output logic                         beatReady,
  input  logic [portalPkg::OFF_W-1:0]  beatOffset,
  input  logic [portalPkg::ID_W-1:0]   beatId,
  input  logic                         beatLast,
  input  logic                         beatCtrl,
  input  logic                         beatInd,
  input  logic                         awAccept,
  input  logic                         wValid,
  output logic                         wReady,
  input  logic [portalPkg::DATA_W-1:0] wData,
  input  logic                         wLast,
  output logic                         bValid,
  input  logic                         bReady,
  output logic [portalPkg::ID_W-1:0]   bId,
  output logic                         reqEnq,
  output logic [portalPkg::DATA_W-1:0] reqData,
  input  logic                         reqReady,
  output logic                         intrEnable
);

  logic userBeat;
  logic consume;
  logic lastSeen;
  logic dataFull;
  logic dataEmpty;
  logic respFull;
  logic respEmpty;
  logic userFull;
  logic userEmpty;
  logic [portalPkg::DATA_W-1:0] word;

  assign userBeat = !beatCtrl && !beatInd;  // Request portal data page

  // Beat, word, response room on last, user room on request data
  assign consume = beatValid && !dataEmpty && (!beatLast || !respFull)
                   && (!userBeat || (reqReady && !userFull));
  assign beatReady = consume;

  assign wReady = !lastSeen && !dataFull;
  assign bValid = !respEmpty;
  assign reqEnq = !userEmpty;

  always_ff @(posedge CLK) begin
    if (!nRST) begin
      lastSeen <= 1'b0;
    end else if (awAccept) begin
      lastSeen <= 1'b0;
    end else if (wValid && wReady && wLast) begin
      lastSeen <= 1'b1;  // Hold data off until the next address
    end
  end

  always_ff @(posedge CLK) begin
    if (!nRST) begin
      intrEnable <= 1'b0;
    end else if (consume && beatCtrl && beatOffset == portalPkg::INTR_ENABLE) begin
      intrEnable <= word[0];
    end
  end

  fifo1 #(.WIDTH(portalPkg::DATA_W)) i_dataStage (
    .CLK(CLK), .nRST(nRST),
    .enq(wValid && wReady), .din(wData),
    .deq(consume), .dout(word),
    .full(dataFull), .empty(dataEmpty)
  );

  fifo1 #(.WIDTH(portalPkg::ID_W)) i_respStage (
    .CLK(CLK), .nRST(nRST),
    .enq(consume && beatLast), .din(beatId),
    .deq(bValid && bReady), .dout(bId),
    .full(respFull), .empty(respEmpty)
  );

  // Indication portal data writes go nowhere
  fifo1 #(.WIDTH(portalPkg::DATA_W)) i_userStage (
    .CLK(CLK), .nRST(nRST),
    .enq(consume && userBeat), .din(word),
    .deq(reqEnq), .dout(reqData),
    .full(userFull), .empty(userEmpty)
  );

  // User queue room must still be there when the staged word leaves
  assert property (@(posedge CLK) disable iff (!nRST) reqEnq |-> reqReady)
    else $error("portalWritePath: user enqueue while not ready");

endmodule

`default_nettype wire

// ==== source/userEcho.sv ====
`timescale 1ns/1ns
`default_nettype none

module userEcho #(
  parameter int DEPTH = 4  // Power of two
) (
  input  logic                         CLK,
  input  logic                         nRST,
  input  logic                         reqEnq,
  input  logic [portalPkg::DATA_W-1:0] reqData,
  output logic                         reqReady,
  input  logic                         indDeq,
  output logic                         indValid,
  output logic [portalPkg::DATA_W-1:0] indData
);

  localparam int PTR_W = $clog2(DEPTH);

  logic [portalPkg::DATA_W-1:0] mem [DEPTH];
  logic [PTR_W-1:0] wrPtr;
  logic [PTR_W-1:0] rdPtr;
  logic [PTR_W:0] count;

  assign reqReady = (count != (PTR_W+1)'(DEPTH));
  assign indValid = (count != '0);
  assign indData = mem[rdPtr];

  always_ff @(posedge CLK) begin
    if (reqEnq) begin
      mem[wrPtr] <= reqData;
    end
  end

  // Pointers wrap on their own
  always_ff @(posedge CLK) begin
    if (!nRST) begin
      wrPtr <= '0;
      rdPtr <= '0;
      count <= '0;
    end else begin
      if (reqEnq) wrPtr <= wrPtr + 1'b1;
      if (indDeq) rdPtr <= rdPtr + 1'b1;
      case ({reqEnq, indDeq})
        2'b10: count <= count + 1'b1;
        2'b01: count <= count - 1'b1;
        default: count <= count;
      endcase
    end
  end

  assert property (@(posedge CLK) disable iff (!nRST) indDeq |-> indValid)
    else $error("userEcho: dequeue while empty");

endmodule

`default_nettype wire

// ==== verif/portalTests.svh ====
task automatic testResetAndIds();
  testName = "testResetAndIds";
  if (rValid !== 1'b0) reportMismatch("rValid after reset", 0, 32'(rValid));
  if (bValid !== 1'b0) reportMismatch("bValid after reset", 0, 32'(bValid));
  if (interrupt !== 1'b0) reportMismatch("interrupt after reset", 0, 32'(interrupt));
  readOne(REQ_CTRL + 13'h10, 32'd5, "request portal id");
  readOne(IND_CTRL + 13'h10, 32'd6, "indication portal id");
  readOne(REQ_CTRL + 13'h14, 32'd2, "portal count");
  readOne(REQ_CTRL + 13'h08, 32'd1, "tile count");
  readOne(REQ_CTRL + 13'h18, FILLER, "unmapped offset");
endtask

// Four beats walk 0x08 to 0x14 on the indication portal
task automatic testControlBurst();
  testName = "testControlBurst";
  busRead(IND_CTRL + 13'h08, 4'd3, 6'h2c, 0);
  if (readWords[0] !== 32'd1) reportMismatch("tile count", 32'd1, readWords[0]);
  if (readWords[1] !== 32'd0) reportMismatch("queue status", 32'd0, readWords[1]);
  if (readWords[2] !== 32'd6) reportMismatch("portal id", 32'd6, readWords[2]);
  if (readWords[3] !== 32'd2) reportMismatch("portal count", 32'd2, readWords[3]);
endtask

task automatic testEcho();
  testName = "testEcho";
  fillWords(4);
  busWrite(REQ_DATA, 4'd3, 6'h15);
  readOne(REQ_CTRL + 13'h0C, 32'd1, "queue status after write");
  busRead(IND_DATA, 4'd3, 6'h16, 0);
  for (int i = 0; i < 4; i++) begin
    if (readWords[i] !== writeWords[i]) reportMismatch("echo word", writeWords[i], readWords[i]);
  end
  readOne(IND_DATA, 32'd0, "read of empty queue");
  readOne(REQ_CTRL + 13'h0C, 32'd0, "queue status after drain");
endtask

task automatic testInterrupt();
  logic [31:0] echoWord;
  testName = "testInterrupt";
  fillWords(1);
  echoWord = writeWords[0];
  busWrite(REQ_DATA, 4'd0, 6'h21);
  readOne(REQ_CTRL + 13'h00, 32'd1, "interrupt status");
  if (interrupt !== 1'b0) reportMismatch("interrupt while disabled", 0, 32'(interrupt));
  writeWords[0] = 32'd1;
  busWrite(REQ_CTRL + 13'h04, 4'd0, 6'h22);
  waitInterrupt(1'b1);
  readOne(IND_CTRL + 13'h04, 32'd1, "enable readback");
  busRead(IND_DATA, 4'd0, 6'h23, 0);
  if (readWords[0] !== echoWord) reportMismatch("drained word", echoWord, readWords[0]);
  waitInterrupt(1'b0);
  writeWords[0] = 32'd0;
  busWrite(REQ_CTRL + 13'h04, 4'd0, 6'h24);
  readOne(REQ_CTRL + 13'h04, 32'd0, "enable cleared");
endtask

// Six words into a depth of four, so the write stalls until reads make room
task automatic testBackPressure();
  logic [31:0] ready;
  int polls;
  testName = "testBackPressure";
  fillWords(6);
  fork
    busWrite(REQ_DATA, 4'd5, 6'h31);
    begin
      polls = 0;
      ready = 32'd1;
      while (ready != 32'd0 && polls < 20) begin
        busRead(REQ_DATA + 13'h04, 4'd0, 6'h32, 0);  // User write-ready bit
        ready = readWords[0];
        polls++;
      end
      if (ready != 32'd0) reportTimeout("write-ready to drop");
      readOne(REQ_CTRL + 13'h0C, 32'd1, "queue status when full");
      if (bValid !== 1'b0) reportMismatch("early write response", 0, 32'(bValid));
      busRead(IND_DATA, 4'd3, 6'h33, 20);
      for (int i = 0; i < 4; i++) begin
        if (readWords[i] !== writeWords[i]) begin
          reportMismatch("stalled read word", writeWords[i], readWords[i]);
        end
      end
    end
  join
  readOne(REQ_CTRL + 13'h0C, 32'd1, "queue status with two left");
  busRead(IND_DATA, 4'd1, 6'h34, 0);
  for (int i = 0; i < 2; i++) begin
    if (readWords[i] !== writeWords[i + 4]) begin
      reportMismatch("late word", writeWords[i + 4], readWords[i]);
    end
  end
  readOne(REQ_CTRL + 13'h0C, 32'd0, "queue status after drain");
endtask

// ==== verif/portalTopTb.sv ====
`timescale 1ns/1ns
`default_nettype none

module portalTopTb;

  localparam int TIMEOUT = 200;  // Cycles allowed per wait
  localparam logic [12:0] REQ_CTRL = 13'h0000;
  localparam logic [12:0] IND_CTRL = 13'h1000;
  localparam logic [12:0] REQ_DATA = 13'h0020;  // Page bits 11:5 nonzero
  localparam logic [12:0] IND_DATA = 13'h1020;
  localparam logic [31:0] FILLER = 32'h005A05A0;

  logic CLK;
  logic nRST;
  logic awValid;
  logic awReady;
  logic [12:0] awAddr;
  logic [5:0] awId;
  logic [3:0] awLen;
  logic wValid;
  logic wReady;
  logic [31:0] wData;
  logic wLast;
  logic bValid;
  logic bReady;
  logic [5:0] bId;
  logic arValid;
  logic arReady;
  logic [12:0] arAddr;
  logic [5:0] arId;
  logic [3:0] arLen;
  logic rValid;
  logic rReady;
  logic [31:0] rData;
  logic [5:0] rId;
  logic rLast;
  logic interrupt;

  int mismatches;
  int timeouts;
  string testName;
  logic [31:0] lfsr;
  logic [31:0] writeWords [16];
  logic [31:0] readWords [16];

  portalTop #(.ECHO_DEPTH(4)) i_portalTop (
    .CLK(CLK), .nRST(nRST),
    .awValid(awValid), .awReady(awReady), .awAddr(awAddr), .awId(awId), .awLen(awLen),
    .wValid(wValid), .wReady(wReady), .wData(wData), .wLast(wLast),
    .bValid(bValid), .bReady(bReady), .bId(bId),
    .arValid(arValid), .arReady(arReady), .arAddr(arAddr), .arId(arId), .arLen(arLen),
    .rValid(rValid), .rReady(rReady), .rData(rData), .rId(rId), .rLast(rLast),
    .interrupt(interrupt)
  );

  initial begin
    CLK = 1'b0;
    forever #10 CLK = ~CLK;
  end

  // Drive and sample point, just after the edge
  task automatic nextCycle();
    @(posedge CLK);
    #2;
  endtask

  function automatic logic [31:0] lfsrStep(input logic [31:0] s);
    if (s[0]) return (s >> 1) ^ 32'h80200003;  // Taps 32 22 2 1
    return s >> 1;
  endfunction

  task automatic randomWord(output logic [31:0] w);
    w = '0;
    for (int i = 0; i < 32; i++) begin
      w = {w[30:0], lfsr[0]};
      lfsr = lfsrStep(lfsr);
    end
  endtask

  task automatic fillWords(input int count);
    for (int i = 0; i < count; i++) begin
      randomWord(writeWords[i]);
    end
  endtask

  task automatic reportMismatch(input string what, input logic [31:0] expected,
                                input logic [31:0] actual);
    mismatches++;
    $display("ERROR %s %s: expected %h, actual %h", testName, what, expected, actual);
  endtask

  task automatic reportTimeout(input string what);
    timeouts++;
    $display("Timeout in %s while waiting for %s", testName, what);
  endtask

  // Words come from writeWords
  task automatic busWrite(input logic [12:0] addr, input logic [3:0] len,
                          input logic [5:0] id);
    int waited;
    awValid = 1'b1;
    awAddr = addr;
    awLen = len;
    awId = id;
    waited = 0;
    while (!awReady && waited < TIMEOUT) begin
      nextCycle();
      waited++;
    end
    if (!awReady) begin
      awValid = 1'b0;
      reportTimeout("awReady");
      return;
    end
    nextCycle();
    awValid = 1'b0;
    for (int i = 0; i <= int'(len); i++) begin
      wValid = 1'b1;
      wData = writeWords[i];
      wLast = (i == int'(len));
      waited = 0;
      while (!wReady && waited < TIMEOUT) begin
        nextCycle();
        waited++;
      end
      if (!wReady) begin
        wValid = 1'b0;
        reportTimeout("wReady");
        return;
      end
      nextCycle();
    end
    wValid = 1'b0;
    wLast = 1'b0;
    bReady = 1'b1;
    waited = 0;
    while (!bValid && waited < TIMEOUT) begin
      nextCycle();
      waited++;
    end
    if (!bValid) begin
      bReady = 1'b0;
      reportTimeout("bValid");
      return;
    end
    if (bId !== id) reportMismatch("bId", 32'(id), 32'(bId));
    nextCycle();
    bReady = 1'b0;
  endtask

  // Beats land in readWords, rReady held low for stall cycles first
  task automatic busRead(input logic [12:0] addr, input logic [3:0] len,
                         input logic [5:0] id, input int stall);
    int waited;
    arValid = 1'b1;
    arAddr = addr;
    arLen = len;
    arId = id;
    waited = 0;
    while (!arReady && waited < TIMEOUT) begin
      nextCycle();
      waited++;
    end
    if (!arReady) begin
      arValid = 1'b0;
      reportTimeout("arReady");
      return;
    end
    nextCycle();
    arValid = 1'b0;
    for (int s = 0; s < stall; s++) begin
      nextCycle();
    end
    rReady = 1'b1;
    for (int i = 0; i <= int'(len); i++) begin
      waited = 0;
      while (!rValid && waited < TIMEOUT) begin
        nextCycle();
        waited++;
      end
      if (!rValid) begin
        rReady = 1'b0;
        reportTimeout("rValid");
        return;
      end
      readWords[i] = rData;
      if (rId !== id) reportMismatch("rId", 32'(id), 32'(rId));
      if (rLast !== (i == int'(len))) reportMismatch("rLast", 32'(i == int'(len)), 32'(rLast));
      nextCycle();
    end
    rReady = 1'b0;
  endtask

  task automatic readOne(input logic [12:0] addr, input logic [31:0] expected,
                         input string what);
    busRead(addr, 4'd0, 6'h01, 0);
    if (readWords[0] !== expected) reportMismatch(what, expected, readWords[0]);
  endtask

  task automatic waitInterrupt(input logic level);
    int waited;
    waited = 0;
    while (interrupt !== level && waited < TIMEOUT) begin
      nextCycle();
      waited++;
    end
    if (interrupt !== level) reportTimeout(level ? "interrupt to rise" : "interrupt to fall");
  endtask

  `include "portalTests.svh"

  initial begin
    nRST = 1'b0;
    awValid = 1'b0;
    awAddr = '0;
    awId = '0;
    awLen = '0;
    wValid = 1'b0;
    wData = '0;
    wLast = 1'b0;
    bReady = 1'b0;
    arValid = 1'b0;
    arAddr = '0;
    arId = '0;
    arLen = '0;
    rReady = 1'b0;
    mismatches = 0;
    timeouts = 0;
    testName = "reset";
    lfsr = 32'h6c0d;
    repeat (2) @(posedge CLK);
    #2;
    nRST = 1'b1;
    testResetAndIds();
    testControlBurst();
    testEcho();
    testInterrupt();
    testBackPressure();
    $display("Mismatches: %0d, timeouts: %0d", mismatches, timeouts);
    if (mismatches == 0 && timeouts == 0) begin
      $display("PASS: all tests");
    end else begin
      $display("FAIL: see errors above");
    end
    $finish;
  end

endmodule

`default_nettype wire
